// ==== common/rvx_defines.svh ====
`ifndef RVX_DEFINES_SVH
`define RVX_DEFINES_SVH

// datapath width of the core
`define RVX_XLEN 64

// word operations work on the low half (addw, sllw, mulw ...)
`define RVX_WLEN 32

// operation code carried by a request
`define RVX_OP_W 5

// shift-add multiplier retires one multiplier bit per cycle
`define RVX_MUL_STEPS `RVX_XLEN

`endif

// ==== common/rvx_pkg.sv ====
`default_nettype none

`include "rvx_defines.svh"

package rvx_pkg;

    // execute operations, branches kept apart from arithmetic
    typedef enum logic [`RVX_OP_W-1:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_XOR  = 5'd4,
        OP_SLL  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_SLT  = 5'd8,
        OP_SLTU = 5'd9,
        OP_MUL  = 5'd10,
        OP_BEQ  = 5'd11,
        OP_BNE  = 5'd12,
        OP_BLT  = 5'd13,
        OP_BGE  = 5'd14,
        OP_BLTU = 5'd15,
        OP_BGEU = 5'd16
    } alu_op_e;

    typedef enum logic {
        EXT_FULL   = 1'b0,  // keep all 64 bits
        EXT_SEXT32 = 1'b1   // sign extend from bit 31
    } ext_mode_e;

    typedef struct packed {
        alu_op_e               op;
        logic                  word;
        logic [`RVX_XLEN-1:0]  src1;
        logic [`RVX_XLEN-1:0]  src2;
    } exu_req_t;

    typedef struct packed {
        logic       use_mul;
        logic       shamt_w;     // 5-bit shift amount
        logic       signed_cmp;
        logic       is_branch;
        ext_mode_e  ext;
        alu_op_e    alu_op;
    } exu_ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [`RVX_XLEN-1:0]  result;
        logic                  taken;
    } exu_rsp_t;

endpackage

`default_nettype wire

// ==== design/alu_comb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvx_defines.svh"

module alu_comb (
    input  rvx_pkg::exu_ctrl_t    ctrl,
    input  logic [`RVX_XLEN-1:0]  src1,
    input  logic [`RVX_XLEN-1:0]  src2,
    output logic [`RVX_XLEN-1:0]  alu_res,
    output logic                  taken
);

    localparam int SHW = $clog2(`RVX_XLEN);
    localparam int HIW = `RVX_XLEN - `RVX_WLEN;

    logic [SHW-1:0]        shamt;
    logic [`RVX_XLEN-1:0]  srl_src;
    logic [`RVX_XLEN-1:0]  sra_src;
    logic                  eq;
    logic                  lt;
    logic                  cond;

    // word shifts only see the low 5 bits of src2
    assign shamt = ctrl.shamt_w ? {1'b0, src2[SHW-2:0]} : src2[SHW-1:0];

    // right shifts on words start from src1[31:0]
    assign srl_src = ctrl.shamt_w ? {{HIW{1'b0}}, src1[`RVX_WLEN-1:0]} : src1;
    assign sra_src = ctrl.shamt_w ? {{HIW{src1[`RVX_WLEN-1]}}, src1[`RVX_WLEN-1:0]} : src1;

    // one comparator shared by slt/sltu and the branches
    assign eq = (src1 == src2);
    assign lt = ctrl.signed_cmp ? ($signed(src1) < $signed(src2)) : (src1 < src2);

    always_comb begin
        case (ctrl.alu_op)
            rvx_pkg::OP_ADD:  alu_res = src1 + src2;
            rvx_pkg::OP_SUB:  alu_res = src1 - src2;
            rvx_pkg::OP_AND:  alu_res = src1 & src2;
            rvx_pkg::OP_OR:   alu_res = src1 | src2;
            rvx_pkg::OP_XOR:  alu_res = src1 ^ src2;
            rvx_pkg::OP_SLL:  alu_res = src1 << shamt;
            rvx_pkg::OP_SRL:  alu_res = srl_src >> shamt;
            rvx_pkg::OP_SRA:  alu_res = $signed(sra_src) >>> shamt;
            rvx_pkg::OP_SLT,
            rvx_pkg::OP_SLTU: alu_res = {{(`RVX_XLEN-1){1'b0}}, lt};
            default:          alu_res = '0;  // mul and branches
        endcase
    end

    // branch condition
    always_comb begin
        case (ctrl.alu_op)
            rvx_pkg::OP_BEQ:  cond = eq;
            rvx_pkg::OP_BNE:  cond = !eq;
            rvx_pkg::OP_BLT,
            rvx_pkg::OP_BLTU: cond = lt;
            rvx_pkg::OP_BGE,
            rvx_pkg::OP_BGEU: cond = !lt;
            default:          cond = 1'b0;
        endcase
    end

    assign taken = ctrl.is_branch && cond;

endmodule

`default_nettype wire

// ==== design/exu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_decode (
    input  rvx_pkg::exu_req_t   req,
    output rvx_pkg::exu_ctrl_t  ctrl,
    output logic                illegal
);

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = req.op;
        ctrl.ext    = rvx_pkg::EXT_FULL;
        illegal     = 1'b0;

        case (req.op)
            rvx_pkg::OP_ADD,
            rvx_pkg::OP_SUB: begin
                if (req.word) begin
                    ctrl.ext = rvx_pkg::EXT_SEXT32;  // addw / subw
                end
            end
            rvx_pkg::OP_SLL,
            rvx_pkg::OP_SRL,
            rvx_pkg::OP_SRA: begin
                ctrl.shamt_w = req.word;  // sllw family masks to 5 bits
                if (req.word) begin
                    ctrl.ext = rvx_pkg::EXT_SEXT32;
                end
            end
            rvx_pkg::OP_MUL: begin
                ctrl.use_mul = 1'b1;
                if (req.word) begin
                    ctrl.ext = rvx_pkg::EXT_SEXT32;  // mulw
                end
            end
            rvx_pkg::OP_SLT: begin
                ctrl.signed_cmp = 1'b1;
                illegal         = req.word;
            end
            rvx_pkg::OP_SLTU: begin
                illegal = req.word;
            end
            rvx_pkg::OP_BLT,
            rvx_pkg::OP_BGE: begin
                ctrl.is_branch  = 1'b1;
                ctrl.signed_cmp = 1'b1;
                illegal         = req.word;
            end
            rvx_pkg::OP_BEQ,
            rvx_pkg::OP_BNE,
            rvx_pkg::OP_BLTU,
            rvx_pkg::OP_BGEU: begin
                ctrl.is_branch = 1'b1;
                illegal        = req.word;
            end
            rvx_pkg::OP_AND,
            rvx_pkg::OP_OR,
            rvx_pkg::OP_XOR: begin
                illegal = req.word;  // no word form of logic ops
            end
            default: begin
                illegal = 1'b1;  // unused encodings
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvx_defines.svh"

module exu_result (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  rvx_pkg::exu_ctrl_t    ctrl,
    input  logic [`RVX_XLEN-1:0]  alu_res,
    input  logic                  taken,
    input  logic [`RVX_XLEN-1:0]  mul_res,
    input  logic                  mul_done,
    input  logic                  illegal,
    output rvx_pkg::exu_rsp_t     rsp
);

    localparam int HIW = `RVX_XLEN - `RVX_WLEN;

    rvx_pkg::ext_mode_e    mul_ext_q;  // mode of the multiply in flight
    logic                  valid_q;
    logic                  taken_q;
    logic [`RVX_XLEN-1:0]  result_q;
    logic                  alu_fire;

    function automatic logic [`RVX_XLEN-1:0] apply_ext(
        input logic [`RVX_XLEN-1:0] val,
        input rvx_pkg::ext_mode_e   mode
    );
        if (mode == rvx_pkg::EXT_SEXT32) begin
            return {{HIW{val[`RVX_WLEN-1]}}, val[`RVX_WLEN-1:0]};
        end
        return val;
    endfunction

    assign alu_fire = req_valid && !ctrl.use_mul;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= alu_fire || mul_done;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fire) begin
            result_q <= apply_ext(alu_res, ctrl.ext);
            taken_q  <= taken;
        end else if (mul_done) begin
            result_q <= apply_ext(mul_res, mul_ext_q);
            taken_q  <= 1'b0;
        end
        if (req_valid && ctrl.use_mul) begin
            mul_ext_q <= ctrl.ext;  // request is gone by completion
        end
    end

    always_comb begin
        rsp.valid  = valid_q;
        rsp.result = result_q;
        rsp.taken  = taken_q;
    end

    // a response stays up only when a new ALU request follows
    a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        valid_q && !alu_fire |=> !valid_q);

    a_no_illegal: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> !illegal);

    // one item in flight, nothing is issued on the multiply completion cycle
    a_single_flight: assert property (@(posedge clk) disable iff (!arst_n)
        mul_done |-> !req_valid);

endmodule

`default_nettype wire

// ==== design/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvx_defines.svh"

module exu_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  rvx_pkg::exu_req_t   req,
    output logic                busy,
    output rvx_pkg::exu_rsp_t   rsp
);

    rvx_pkg::exu_ctrl_t    ctrl;
    logic                  illegal;
    logic [`RVX_XLEN-1:0]  alu_res;
    logic [`RVX_XLEN-1:0]  mul_res;
    logic                  taken;
    logic                  mul_done;
    logic                  mul_start;

    assign mul_start = req_valid && ctrl.use_mul;

    exu_decode u_decode (
        .req     (req),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    alu_comb u_alu (
        .ctrl    (ctrl),
        .src1    (req.src1),
        .src2    (req.src2),
        .alu_res (alu_res),
        .taken   (taken)
    );

    // word multiplies use full operands, low half is unaffected
    mul_shift_add u_mul (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (mul_start),
        .src1     (req.src1),
        .src2     (req.src2),
        .busy     (busy),
        .mul_done (mul_done),
        .mul_res  (mul_res)
    );

    exu_result u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .ctrl      (ctrl),
        .alu_res   (alu_res),
        .taken     (taken),
        .mul_res   (mul_res),
        .mul_done  (mul_done),
        .illegal   (illegal),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== dv/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvx_defines.svh"

module exu_tb;

    localparam int NUM_RANDOM   = 200;
    localparam int NUM_DIRECTED = 100;  // upper bound on directed requests
    localparam int MUL_LAT      = `RVX_MUL_STEPS + 1;
    localparam int TIMEOUT_CYCLES = 8 + (NUM_RANDOM + NUM_DIRECTED) * (`RVX_MUL_STEPS + 2) + 500;

    logic               clk;
    logic               arst_n;
    logic               req_valid;
    rvx_pkg::exu_req_t  req;
    logic               busy;
    rvx_pkg::exu_rsp_t  rsp;

    integer             seed = 65891;
    int                 cyc = 0;
    rvx_pkg::exu_rsp_t  exp_q[$];   // expected responses in issue order
    int                 due_q[$];   // cycle each response is due
    rvx_pkg::exu_rsp_t  exp_rsp;
    int                 due;

    exu_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp       (rsp)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare_result(input logic [`RVX_XLEN-1:0] got,
                                  input logic [`RVX_XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: rsp.result got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic compare_taken(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: rsp.taken got 0x%h expected 0x%h", got, exp));
        end
    endtask

    function automatic logic [`RVX_XLEN-1:0] sign_extend_word(input logic [`RVX_XLEN-1:0] v);
        return {{(`RVX_XLEN-`RVX_WLEN){v[`RVX_WLEN-1]}}, v[`RVX_WLEN-1:0]};
    endfunction

    // expected response from the ISA rules
    function automatic rvx_pkg::exu_rsp_t ref_exu(input rvx_pkg::exu_req_t r);
        rvx_pkg::exu_rsp_t     o;
        logic [`RVX_XLEN-1:0]  a;
        logic [`RVX_XLEN-1:0]  b;
        logic [`RVX_XLEN-1:0]  res;
        int                    sh;
        o = '0;
        o.valid = 1'b1;
        a = r.src1;
        b = r.src2;
        res = '0;
        sh = r.word ? int'(b[4:0]) : int'(b[5:0]);
        case (r.op)
            rvx_pkg::OP_ADD:  res = a + b;
            rvx_pkg::OP_SUB:  res = a - b;
            rvx_pkg::OP_AND:  res = a & b;
            rvx_pkg::OP_OR:   res = a | b;
            rvx_pkg::OP_XOR:  res = a ^ b;
            rvx_pkg::OP_SLL:  res = a << sh;
            rvx_pkg::OP_SRL:  res = r.word ? ({32'b0, a[31:0]} >> sh) : (a >> sh);
            rvx_pkg::OP_SRA:  res = $signed(r.word ? sign_extend_word(a) : a) >>> sh;
            rvx_pkg::OP_SLT:  res = {63'b0, $signed(a) < $signed(b)};
            rvx_pkg::OP_SLTU: res = {63'b0, a < b};
            rvx_pkg::OP_MUL:  res = a * b;  // low 64 bits
            rvx_pkg::OP_BEQ:  o.taken = (a == b);
            rvx_pkg::OP_BNE:  o.taken = (a != b);
            rvx_pkg::OP_BLT:  o.taken = ($signed(a) < $signed(b));
            rvx_pkg::OP_BGE:  o.taken = ($signed(a) >= $signed(b));
            rvx_pkg::OP_BLTU: o.taken = (a < b);
            rvx_pkg::OP_BGEU: o.taken = (a >= b);
            default:          res = '0;
        endcase
        o.result = r.word ? sign_extend_word(res) : res;
        return o;
    endfunction

    function automatic logic [`RVX_XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic word_allowed(input rvx_pkg::alu_op_e op);
        return op == rvx_pkg::OP_ADD || op == rvx_pkg::OP_SUB || op == rvx_pkg::OP_SLL ||
               op == rvx_pkg::OP_SRL || op == rvx_pkg::OP_SRA || op == rvx_pkg::OP_MUL;
    endfunction

    // called 1 ns after a rising edge, returns at the same point
    task automatic issue_req(input int op, input logic word,
                             input logic [`RVX_XLEN-1:0] a, input logic [`RVX_XLEN-1:0] b);
        rvx_pkg::exu_req_t r;
        int                busy_cycles;
        r.op   = rvx_pkg::alu_op_e'(op);
        r.word = word;
        r.src1 = a;
        r.src2 = b;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(ref_exu(r));
        due_q.push_back(cyc + ((r.op == rvx_pkg::OP_MUL) ? MUL_LAT : 1));
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (r.op == rvx_pkg::OP_MUL) begin
            if (!busy) begin
                report_failure("busy did not rise after a multiply request");
            end
            busy_cycles = 0;
            while (busy) begin
                busy_cycles++;
                @(posedge clk);
                #1;
            end
            if (busy_cycles != `RVX_MUL_STEPS) begin
                report_failure($sformatf("busy was high for %0d cycles instead of %0d",
                                         busy_cycles, `RVX_MUL_STEPS));
            end
        end
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == TIMEOUT_CYCLES) begin
            report_failure("timeout, the run did not finish within the cycle limit");
        end
    end

    // response checker, samples mid cycle
    always @(negedge clk) begin
        if (arst_n && rsp.valid) begin
            if (exp_q.size() == 0) begin
                report_failure("response valid seen with no request outstanding");
            end
            exp_rsp = exp_q.pop_front();
            due     = due_q.pop_front();
            if (cyc != due) begin
                report_failure($sformatf("response came in cycle %0d but was due in cycle %0d",
                                         cyc, due));
            end
            compare_result(rsp.result, exp_rsp.result);
            compare_taken(rsp.taken, exp_rsp.taken);
        end
    end

    initial begin
        logic [`RVX_XLEN-1:0] a;
        logic [`RVX_XLEN-1:0] b;
        int                   op;
        logic                 word;
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (busy !== 1'b0 || rsp.valid !== 1'b0) begin
            report_failure("busy or rsp.valid was not low after reset");
        end

        // full width arithmetic, logic and compares
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k <= 4; k++) begin
                issue_req(k, 1'b0, rand64(), rand64());
            end
            issue_req(rvx_pkg::OP_SLT, 1'b0, rand64(), rand64());
            issue_req(rvx_pkg::OP_SLTU, 1'b0, rand64(), rand64());
        end

        // shifts, random src2 upper bits check the amount mask
        for (int i = 0; i < 4; i++) begin
            for (int k = rvx_pkg::OP_SLL; k <= rvx_pkg::OP_SRA; k++) begin
                issue_req(k, 1'b0, rand64(), rand64());
                issue_req(k, 1'b1, rand64(), rand64());
            end
        end

        // branches with equal operands and sign bits set
        for (int k = rvx_pkg::OP_BEQ; k <= rvx_pkg::OP_BGEU; k++) begin
            a = rand64();
            issue_req(k, 1'b0, a, a);
            issue_req(k, 1'b0, a, rand64());
            issue_req(k, 1'b0, a | (64'd1 << 63), rand64() & ~(64'd1 << 63));
            issue_req(k, 1'b0, rand64() & ~(64'd1 << 63), a | (64'd1 << 63));
        end

        // multiplies, full and word
        for (int w = 0; w < 2; w++) begin
            issue_req(rvx_pkg::OP_MUL, w[0], '0, rand64());
            issue_req(rvx_pkg::OP_MUL, w[0], '1, rand64());
            issue_req(rvx_pkg::OP_MUL, w[0], '1, '1);
            issue_req(rvx_pkg::OP_MUL, w[0], rand64(), rand64());
            issue_req(rvx_pkg::OP_MUL, w[0], rand64(), rand64());
        end

        // mixed random legal requests
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op   = {$random(seed)} % 17;
            a    = rand64();
            b    = rand64();
            word = (($random(seed) & 1) != 0) && word_allowed(rvx_pkg::alu_op_e'(op));
            issue_req(op, word, a, b);
        end

        while (busy) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
            $display("TB FAILED");
            $fatal(1);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== multiplier/mul_shift_add.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvx_defines.svh"

module mul_shift_add (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`RVX_XLEN-1:0]  src1,
    input  logic [`RVX_XLEN-1:0]  src2,
    output logic                  busy,
    output logic                  mul_done,
    output logic [`RVX_XLEN-1:0]  mul_res
);

    localparam int CNT_W = $clog2(`RVX_MUL_STEPS);

    logic [`RVX_XLEN-1:0]  mcand_q;   // shifts left
    logic [`RVX_XLEN-1:0]  mplier_q;  // shifts right
    logic [`RVX_XLEN-1:0]  acc_q;
    logic [`RVX_XLEN-1:0]  acc_nxt;
    logic [CNT_W-1:0]      cnt_q;
    logic                  busy_q;
    logic                  last_step;

    // partial product of the current step
    assign acc_nxt   = acc_q + (mplier_q[0] ? mcand_q : '0);
    assign last_step = (cnt_q == CNT_W'(`RVX_MUL_STEPS - 1));

    // final step is added combinationally, so the product is ready with mul_done
    assign mul_res  = acc_nxt;
    assign mul_done = busy_q && last_step;
    assign busy     = busy_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_step) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand_q  <= src1;
            mplier_q <= src2;
            acc_q    <= '0;
        end else if (busy_q) begin
            acc_q    <= acc_nxt;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // the issue logic must hold off while a product is in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy_q);

    // done arrives on the last of the busy cycles
    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(busy_q) |-> ##(`RVX_MUL_STEPS-1) mul_done);

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/rvx_pkg.sv
design/exu_decode.sv
design/alu_comb.sv
multiplier/mul_shift_add.sv
design/exu_result.sv
design/exu_top.sv
dv/exu_tb.sv
